// ==== verilog/rv_dmem_pkg.sv ====
/*
 * rv32i data-access stage shared definitions
 *   load/store size codes, stage states, I/O region code and bus width
 */

package rv_dmem_pkg;

	// data and address width
	parameter int XLEN = 32;

	// funct3 of loads and stores, bit 2 marks unsigned
	typedef enum logic [2:0] {
		LS_B  = 3'b000,
		LS_H  = 3'b001,
		LS_W  = 3'b010,
		LS_BU = 3'b100,
		LS_HU = 3'b101
	} ldst_code_e;

	// data-access stage FSM
	typedef enum logic [2:0] {
		ST_IDLE = 3'b000,
		ST_MEM  = 3'b001,
		ST_IOR  = 3'b010,
		ST_DONE = 3'b011
	} access_state_e;

	// addr[31:30] of the I/O register space
	localparam logic [1:0] IO_REGION = 2'b11;

endpackage

// ==== verilog/data_ram.sv ====
/*
 * wishbone classic data RAM
 *   word addressed, byte lane writes, registered read and ack
 */

`timescale 1ns/1ns

module data_ram #(
	parameter int RAM_ADDR_WIDTH = 8
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          cyc,
	input  logic                          stb,
	input  logic                          we,
	input  logic [rv_dmem_pkg::XLEN-1:0]  adr,
	input  logic [3:0]                    sel,
	input  logic [rv_dmem_pkg::XLEN-1:0]  dat_w,
	output logic [rv_dmem_pkg::XLEN-1:0]  dat_r,
	output logic                          ack
);

	localparam int DEPTH = 1 << RAM_ADDR_WIDTH;

	logic [rv_dmem_pkg::XLEN-1:0] mem [0:DEPTH-1];
	logic [RAM_ADDR_WIDTH-1:0]    word_adr;
	logic                         req;

	assign word_adr = adr[RAM_ADDR_WIDTH+1:2];
	// one access per strobe, the ack cycle is not a new request
	assign req      = cyc & stb & ~ack;

	always_ff @(posedge clk) begin
		if (req && we) begin
			for (int b = 0; b < 4; b++) begin
				if (sel[b])
					mem[word_adr][b*8 +: 8] <= dat_w[b*8 +: 8];
			end
		end
		if (req)
			dat_r <= mem[word_adr];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ack <= 1'b0;
		else
			ack <= req;
	end

	// the granted request and its address stay put until the ack
	a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		(cyc && stb && !ack) |=> (cyc && stb && $stable(adr)));

endmodule

// ==== verilog/io_regs.sv ====
/*
 * I/O register bank
 *   word writes on a strobe, read value registered on the read strobe
 */

`timescale 1ns/1ns

module io_regs #(
	parameter int IO_ADDR_WIDTH = 3
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          we,
	input  logic                          re,
	input  logic [IO_ADDR_WIDTH-1:0]      adr,
	input  logic [rv_dmem_pkg::XLEN-1:0]  wdata,
	output logic [rv_dmem_pkg::XLEN-1:0]  rdata
);

	localparam int NREGS = 1 << IO_ADDR_WIDTH;

	logic [rv_dmem_pkg::XLEN-1:0] regs [0:NREGS-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
			rdata <= '0;
		end else begin
			if (we)
				regs[adr] <= wdata;
			// read value holds until the next read strobe
			if (re)
				rdata <= regs[adr];
		end
	end

endmodule

// ==== verilog/wb_arbiter.sv ====
/*
 * two-master wishbone classic arbiter
 *   round-robin grant, held until the granted master drops cyc
 */

`timescale 1ns/1ns

module wb_arbiter (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          m0_cyc,
	input  logic                          m0_stb,
	input  logic                          m0_we,
	input  logic [rv_dmem_pkg::XLEN-1:0]  m0_adr,
	input  logic [3:0]                    m0_sel,
	input  logic [rv_dmem_pkg::XLEN-1:0]  m0_dat_w,
	input  logic                          m1_cyc,
	input  logic                          m1_stb,
	input  logic                          m1_we,
	input  logic [rv_dmem_pkg::XLEN-1:0]  m1_adr,
	input  logic [3:0]                    m1_sel,
	input  logic [rv_dmem_pkg::XLEN-1:0]  m1_dat_w,
	input  logic [rv_dmem_pkg::XLEN-1:0]  s_dat_r,
	input  logic                          s_ack,
	output logic                          m0_ack,
	output logic                          m1_ack,
	output logic [rv_dmem_pkg::XLEN-1:0]  m_dat_r,
	output logic                          s_cyc,
	output logic                          s_stb,
	output logic                          s_we,
	output logic [rv_dmem_pkg::XLEN-1:0]  s_adr,
	output logic [3:0]                    s_sel,
	output logic [rv_dmem_pkg::XLEN-1:0]  s_dat_w
);

	logic gnt_q;
	logic last_q;
	logic open_q;
	logic held;
	logic pick;
	logic gnt;

	// owner keeps the bus while the cycle it opened is still open
	assign held = open_q & (gnt_q ? m1_cyc : m0_cyc);

	always_comb begin
		pick = gnt_q;
		if (m0_cyc && m1_cyc)
			pick = ~last_q;
		else if (m0_cyc)
			pick = 1'b0;
		else if (m1_cyc)
			pick = 1'b1;
	end

	assign gnt = held ? gnt_q : pick;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gnt_q  <= 1'b0;
			last_q <= 1'b1;
			open_q <= 1'b0;
		end else begin
			gnt_q  <= gnt;
			open_q <= s_cyc;
			if (s_ack)
				last_q <= gnt;
		end
	end

	assign s_cyc   = gnt ? m1_cyc   : m0_cyc;
	assign s_stb   = gnt ? m1_stb   : m0_stb;
	assign s_we    = gnt ? m1_we    : m0_we;
	assign s_adr   = gnt ? m1_adr   : m0_adr;
	assign s_sel   = gnt ? m1_sel   : m0_sel;
	assign s_dat_w = gnt ? m1_dat_w : m0_dat_w;

	assign m0_ack  = s_ack & ~gnt;
	assign m1_ack  = s_ack & gnt;
	assign m_dat_r = s_dat_r;

	a_gnt_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(s_cyc && !s_ack) |=> (gnt == $past(gnt)));

endmodule

// ==== verilog/mem_access_stage.sv ====
/*
 * rv32i data-access stage
 *   region decode, wishbone master cycle to the data RAM, I/O strobes,
 *   byte lane placement for stores and extension of load results
 */

`timescale 1ns/1ns

module mem_access_stage #(
	parameter int IO_ADDR_WIDTH = 3
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            cmd_ld,
	input  logic                            cmd_st,
	input  rv_dmem_pkg::ldst_code_e         ldst_code,
	input  logic [rv_dmem_pkg::XLEN-1:0]    addr,
	input  logic [rv_dmem_pkg::XLEN-1:0]    st_data,
	input  logic [4:0]                      rd_adr,
	input  logic                            wbk_rd_reg,
	input  logic [rv_dmem_pkg::XLEN-1:0]    rd_data,
	input  logic [rv_dmem_pkg::XLEN-1:0]    m_dat_r,
	input  logic                            m_ack,
	input  logic [rv_dmem_pkg::XLEN-1:0]    io_rdata,
	output logic                            busy,
	output logic                            done,
	output logic                            wb_en,
	output logic [4:0]                      wb_rd_adr,
	output logic [rv_dmem_pkg::XLEN-1:0]    wb_data,
	output logic                            m_cyc,
	output logic                            m_stb,
	output logic                            m_we,
	output logic [rv_dmem_pkg::XLEN-1:0]    m_adr,
	output logic [3:0]                      m_sel,
	output logic [rv_dmem_pkg::XLEN-1:0]    m_dat_w,
	output logic                            io_we,
	output logic                            io_re,
	output logic [IO_ADDR_WIDTH-1:0]        io_adr,
	output logic [rv_dmem_pkg::XLEN-1:0]    io_wdata
);

	rv_dmem_pkg::access_state_e state_q, state_d;
	logic                          is_io;
	logic                          io_pend;
	logic                          accept;
	logic                          io_we_q;
	logic                          io_re_q;
	logic                          m_cyc_q;
	logic [rv_dmem_pkg::XLEN-1:0]  ram_q;
	logic [rv_dmem_pkg::XLEN-1:0]  lane_word;
	logic [rv_dmem_pkg::XLEN-1:0]  ld_ext;
	logic                          fill;

	assign is_io   = (addr[31:30] == rv_dmem_pkg::IO_REGION);
	assign io_pend = io_we_q | io_re_q;
	// new load/store taken only from idle with no I/O strobe in flight
	assign accept  = (state_q == rv_dmem_pkg::ST_IDLE) & ~io_pend & (cmd_ld | cmd_st);

	always_comb begin
		state_d = state_q;
		case (state_q)
			rv_dmem_pkg::ST_IDLE: begin
				if (io_pend)
					state_d = io_re_q ? rv_dmem_pkg::ST_IOR : rv_dmem_pkg::ST_DONE;
				else if (accept && !is_io)
					state_d = rv_dmem_pkg::ST_MEM;
			end
			rv_dmem_pkg::ST_MEM:  if (m_ack) state_d = rv_dmem_pkg::ST_DONE;
			rv_dmem_pkg::ST_IOR:  state_d = rv_dmem_pkg::ST_DONE;
			default:              state_d = rv_dmem_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= rv_dmem_pkg::ST_IDLE;
			m_cyc_q <= 1'b0;
			io_we_q <= 1'b0;
			io_re_q <= 1'b0;
		end else begin
			state_q <= state_d;
			m_cyc_q <= (state_d == rv_dmem_pkg::ST_MEM);
			io_we_q <= accept & is_io & cmd_st;
			io_re_q <= accept & is_io & cmd_ld;
		end
	end

	// returned RAM word, held until the writeback
	always_ff @(posedge clk) begin
		if (m_ack)
			ram_q <= m_dat_r;
	end

	// wishbone master side
	assign m_cyc = m_cyc_q;
	assign m_stb = m_cyc_q;
	assign m_we  = cmd_st;
	assign m_adr = addr;

	always_comb begin
		m_dat_w = st_data << {addr[1:0], 3'b000};
		case (ldst_code[1:0])
			2'b00:   m_sel = 4'b0001 << addr[1:0];
			2'b01:   m_sel = 4'b0011 << {addr[1], 1'b0};
			default: m_sel = 4'b1111;
		endcase
	end

	// I/O side is word wide
	assign io_we    = io_we_q;
	assign io_re    = io_re_q;
	assign io_adr   = addr[IO_ADDR_WIDTH+1:2];
	assign io_wdata = st_data;

	// pick the addressed lane and extend
	always_comb begin
		lane_word = (is_io ? io_rdata : ram_q) >> {addr[1:0], 3'b000};
		case (ldst_code[1:0])
			2'b00: begin
				fill   = ~ldst_code[2] & lane_word[7];
				ld_ext = {{24{fill}}, lane_word[7:0]};
			end
			2'b01: begin
				fill   = ~ldst_code[2] & lane_word[15];
				ld_ext = {{16{fill}}, lane_word[15:0]};
			end
			default: begin
				fill   = 1'b0;
				ld_ext = is_io ? io_rdata : ram_q;
			end
		endcase
	end

	// pass-through completes combinationally from idle
	assign busy      = (state_q != rv_dmem_pkg::ST_IDLE) | io_pend;
	assign done      = (state_q == rv_dmem_pkg::ST_DONE) |
	                   (~busy & ~cmd_ld & ~cmd_st);
	assign wb_en     = done & (busy ? cmd_ld : wbk_rd_reg);
	assign wb_rd_adr = rd_adr;
	assign wb_data   = busy ? ld_ext : rd_data;

	// bus request stays up with cyc until the RAM answers
	a_stb_held: assert property (@(posedge clk) disable iff (!rst_n)
		(m_stb && !m_ack) |=> (m_stb && m_cyc));

	// a memory or I/O completion is a single pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		(busy && done) |=> !(busy && done));

	a_no_io_on_bus: assert property (@(posedge clk) disable iff (!rst_n)
		m_cyc |-> (addr[31:30] != rv_dmem_pkg::IO_REGION));

endmodule

// ==== verilog/rv_dmem_top.sv ====
/*
 * rv32i data-access subsystem
 *   stage, RAM arbiter, data RAM and I/O bank, with the fetch port brought out
 */

`timescale 1ns/1ns

module rv_dmem_top #(
	parameter int RAM_ADDR_WIDTH = 8,
	parameter int IO_ADDR_WIDTH  = 3
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          cmd_ld,
	input  logic                          cmd_st,
	input  rv_dmem_pkg::ldst_code_e       ldst_code,
	input  logic [rv_dmem_pkg::XLEN-1:0]  addr,
	input  logic [rv_dmem_pkg::XLEN-1:0]  st_data,
	input  logic [4:0]                    rd_adr,
	input  logic                          wbk_rd_reg,
	input  logic [rv_dmem_pkg::XLEN-1:0]  rd_data,
	input  logic                          fetch_cyc,
	input  logic                          fetch_stb,
	input  logic [rv_dmem_pkg::XLEN-1:0]  fetch_adr,
	output logic                          busy,
	output logic                          done,
	output logic                          wb_en,
	output logic [4:0]                    wb_rd_adr,
	output logic [rv_dmem_pkg::XLEN-1:0]  wb_data,
	output logic [rv_dmem_pkg::XLEN-1:0]  fetch_dat,
	output logic                          fetch_ack
);

	logic                          m0_cyc, m0_stb, m0_we, m0_ack;
	logic [rv_dmem_pkg::XLEN-1:0]  m0_adr, m0_dat_w, m_dat_r;
	logic [3:0]                    m0_sel;
	logic                          s_cyc, s_stb, s_we, s_ack;
	logic [rv_dmem_pkg::XLEN-1:0]  s_adr, s_dat_w, s_dat_r;
	logic [3:0]                    s_sel;
	logic                          io_we, io_re;
	logic [IO_ADDR_WIDTH-1:0]      io_adr;
	logic [rv_dmem_pkg::XLEN-1:0]  io_wdata, io_rdata;

	assign fetch_dat = m_dat_r;

	mem_access_stage #(.IO_ADDR_WIDTH(IO_ADDR_WIDTH)) u_stage (
		.clk, .rst_n, .cmd_ld, .cmd_st, .ldst_code, .addr, .st_data,
		.rd_adr, .wbk_rd_reg, .rd_data,
		.m_dat_r(m_dat_r), .m_ack(m0_ack), .io_rdata(io_rdata),
		.busy, .done, .wb_en, .wb_rd_adr, .wb_data,
		.m_cyc(m0_cyc), .m_stb(m0_stb), .m_we(m0_we), .m_adr(m0_adr),
		.m_sel(m0_sel), .m_dat_w(m0_dat_w),
		.io_we(io_we), .io_re(io_re), .io_adr(io_adr), .io_wdata(io_wdata)
	);

	// fetch is always a full word read
	wb_arbiter u_arb (
		.clk, .rst_n,
		.m0_cyc(m0_cyc), .m0_stb(m0_stb), .m0_we(m0_we), .m0_adr(m0_adr),
		.m0_sel(m0_sel), .m0_dat_w(m0_dat_w),
		.m1_cyc(fetch_cyc), .m1_stb(fetch_stb), .m1_we(1'b0), .m1_adr(fetch_adr),
		.m1_sel(4'b1111), .m1_dat_w('0),
		.s_dat_r(s_dat_r), .s_ack(s_ack),
		.m0_ack(m0_ack), .m1_ack(fetch_ack), .m_dat_r(m_dat_r),
		.s_cyc(s_cyc), .s_stb(s_stb), .s_we(s_we), .s_adr(s_adr),
		.s_sel(s_sel), .s_dat_w(s_dat_w)
	);

	data_ram #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) u_ram (
		.clk, .rst_n, .cyc(s_cyc), .stb(s_stb), .we(s_we), .adr(s_adr),
		.sel(s_sel), .dat_w(s_dat_w), .dat_r(s_dat_r), .ack(s_ack)
	);

	io_regs #(.IO_ADDR_WIDTH(IO_ADDR_WIDTH)) u_io (
		.clk, .rst_n, .we(io_we), .re(io_re), .adr(io_adr),
		.wdata(io_wdata), .rdata(io_rdata)
	);

endmodule

// ==== dv/tb_rv_dmem.sv ====
/*
 * testbench for the rv32i data-access subsystem
 *   table of loads, stores and pass-throughs checked against a byte model,
 *   with random instruction fetches sharing the data RAM
 */

`timescale 1ns/1ns

module tb_rv_dmem;

	localparam int CLK_PERIOD      = 4;
	localparam int NROWS           = 24;
	localparam int NFETCH          = 16;
	localparam int WATCHDOG_CYCLES = (NROWS + NFETCH) * 20 + 10;
	localparam logic [31:0] IO_BASE = {rv_dmem_pkg::IO_REGION, 30'h0};

	typedef enum logic [1:0] {OP_PASS, OP_LOAD, OP_STORE} op_e;

	typedef struct packed {
		op_e                     op;
		rv_dmem_pkg::ldst_code_e code;
		logic [31:0]             addr;
		logic [31:0]             st_data;
		logic [4:0]              rd_adr;
		logic                    wbk;
		logic [31:0]             rd_data;
		logic [31:0]             exp;
	} row_t;

	logic clk, rst_n, cmd_ld, cmd_st, wbk_rd_reg;
	logic fetch_cyc, fetch_stb, fetch_ack;
	rv_dmem_pkg::ldst_code_e ldst_code;
	logic [31:0] addr, st_data, rd_data, fetch_adr, fetch_dat, wb_data;
	logic [4:0]  rd_adr, wb_rd_adr;
	logic        busy, done, wb_en;
	logic        fetch_go, fetch_done;
	integer      seed = 91;

	// reference model of RAM bytes and I/O words
	logic [7:0]  ram_ref [0:1023];
	logic [31:0] io_ref [0:7];
	row_t        rows [0:NROWS-1];
	int          nrows;

	rv_dmem_top #(.RAM_ADDR_WIDTH(8), .IO_ADDR_WIDTH(3)) DUT (
		.clk, .rst_n, .cmd_ld, .cmd_st, .ldst_code, .addr, .st_data, .rd_adr,
		.wbk_rd_reg, .rd_data, .fetch_cyc, .fetch_stb, .fetch_adr,
		.busy, .done, .wb_en, .wb_rd_adr, .wb_data, .fetch_dat, .fetch_ack
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_rd(input string name, input logic [4:0] exp, input logic [4:0] act);
		if (exp !== act) begin
			$display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	function automatic logic [31:0] ram_word(input logic [31:0] a);
		logic [9:0] b;
		b = {a[9:2], 2'b00};
		return {ram_ref[b + 3], ram_ref[b + 2], ram_ref[b + 1], ram_ref[b]};
	endfunction

	// lane select by address, sign or zero fill by size code
	function automatic logic [31:0] load_value(input rv_dmem_pkg::ldst_code_e code,
			input logic [31:0] a, input logic [31:0] w);
		logic [31:0] sh;
		sh = w >> (8 * a[1:0]);
		case (code)
			rv_dmem_pkg::LS_B:  return {{24{sh[7]}}, sh[7:0]};
			rv_dmem_pkg::LS_BU: return {24'h0, sh[7:0]};
			rv_dmem_pkg::LS_H:  return {{16{sh[15]}}, sh[15:0]};
			rv_dmem_pkg::LS_HU: return {16'h0, sh[15:0]};
			default:            return w;
		endcase
	endfunction

	// appends a row and keeps the model in step with it
	task automatic add_row(input op_e op, input rv_dmem_pkg::ldst_code_e code,
			input logic [31:0] a, input logic [31:0] d, input logic [4:0] rd,
			input logic wbk, input logic [31:0] alu);
		row_t       r;
		logic       is_io;
		logic [9:0] base;
		int         nb;
		int         b;
		is_io = (a[31:30] == rv_dmem_pkg::IO_REGION);
		nb    = (code[1:0] == 2'b00) ? 1 : (code[1:0] == 2'b01) ? 2 : 4;
		base  = (nb == 4) ? {a[9:2], 2'b00} : a[9:0];
		r     = {op, code, a, d, rd, wbk, alu, alu};
		if (op == OP_STORE && is_io)
			io_ref[a[4:2]] = d;
		else if (op == OP_STORE)
			for (b = 0; b < nb; b++)
				ram_ref[base + b] = d[8*b +: 8];
		else if (op == OP_LOAD)
			r.exp = load_value(code, a, is_io ? io_ref[a[4:2]] : ram_word(a));
		if (nrows < NROWS)
			rows[nrows] = r;
		nrows++;
	endtask

	task automatic fill_table();
		int i;
		nrows = 0;
		for (i = 0; i < 8; i++)
			io_ref[i] = '0;
		// words 0..3 are the fetch region, written once here
		add_row(OP_STORE, rv_dmem_pkg::LS_W, 32'h000, 32'h12345678, 5'd1, 1'b0, 32'h0);
		add_row(OP_STORE, rv_dmem_pkg::LS_W, 32'h004, 32'h8899aabb, 5'd2, 1'b0, 32'h0);
		add_row(OP_STORE, rv_dmem_pkg::LS_W, 32'h008, 32'hdeadbeef, 5'd3, 1'b0, 32'h0);
		add_row(OP_STORE, rv_dmem_pkg::LS_W, 32'h00c, 32'h0badf00d, 5'd4, 1'b0, 32'h0);
		add_row(OP_LOAD,  rv_dmem_pkg::LS_W, 32'h004, 32'h0, 5'd5, 1'b0, 32'h0);
		// sub-word lanes inside one word
		add_row(OP_STORE, rv_dmem_pkg::LS_W,  32'h040, 32'hffffffff, 5'd0, 1'b0, 32'h0);
		add_row(OP_STORE, rv_dmem_pkg::LS_B,  32'h041, 32'h77777712, 5'd0, 1'b0, 32'h0);
		add_row(OP_STORE, rv_dmem_pkg::LS_H,  32'h042, 32'h55558001, 5'd0, 1'b0, 32'h0);
		add_row(OP_LOAD,  rv_dmem_pkg::LS_W,  32'h040, 32'h0, 5'd6, 1'b0, 32'h0);
		add_row(OP_LOAD,  rv_dmem_pkg::LS_B,  32'h043, 32'h0, 5'd7, 1'b0, 32'h0);
		add_row(OP_LOAD,  rv_dmem_pkg::LS_BU, 32'h043, 32'h0, 5'd8, 1'b0, 32'h0);
		add_row(OP_LOAD,  rv_dmem_pkg::LS_H,  32'h042, 32'h0, 5'd11, 1'b0, 32'h0);
		add_row(OP_LOAD,  rv_dmem_pkg::LS_HU, 32'h042, 32'h0, 5'd12, 1'b0, 32'h0);
		add_row(OP_LOAD,  rv_dmem_pkg::LS_B,  32'h041, 32'h0, 5'd13, 1'b0, 32'h0);
		add_row(OP_LOAD,  rv_dmem_pkg::LS_H,  32'h040, 32'h0, 5'd14, 1'b0, 32'h0);
		// I/O register at the same low address as a RAM word
		add_row(OP_STORE, rv_dmem_pkg::LS_W, 32'h010, 32'h5555aaaa, 5'd0, 1'b0, 32'h0);
		add_row(OP_STORE, rv_dmem_pkg::LS_W, IO_BASE + 32'h10, 32'hcafe0001, 5'd0, 1'b0, 32'h0);
		add_row(OP_LOAD,  rv_dmem_pkg::LS_W, IO_BASE + 32'h10, 32'h0, 5'd15, 1'b0, 32'h0);
		add_row(OP_LOAD,  rv_dmem_pkg::LS_W, 32'h010, 32'h0, 5'd16, 1'b0, 32'h0);
		add_row(OP_PASS,  rv_dmem_pkg::LS_W, 32'h0, 32'h0, 5'd9, 1'b1, 32'h00000abc);
		add_row(OP_PASS,  rv_dmem_pkg::LS_W, 32'h0, 32'h0, 5'd10, 1'b0, 32'h00000001);
		add_row(OP_STORE, rv_dmem_pkg::LS_W, IO_BASE + 32'h1c, 32'h00000007, 5'd0, 1'b0, 32'h0);
		add_row(OP_LOAD,  rv_dmem_pkg::LS_W, IO_BASE + 32'h1c, 32'h0, 5'd17, 1'b0, 32'h0);
		add_row(OP_LOAD,  rv_dmem_pkg::LS_BU, 32'h00c, 32'h0, 5'd18, 1'b0, 32'h0);
	endtask

	// called on a falling edge, returns on the falling edge after done
	task automatic apply_row(input int i);
		row_t r;
		logic en;
		r          = rows[i];
		en         = (r.op == OP_LOAD) || (r.op == OP_PASS && r.wbk);
		cmd_ld     = (r.op == OP_LOAD);
		cmd_st     = (r.op == OP_STORE);
		ldst_code  = r.code;
		addr       = r.addr;
		st_data    = r.st_data;
		rd_adr     = r.rd_adr;
		wbk_rd_reg = r.wbk;
		rd_data    = r.rd_data;
		#1;
		while (!done) begin
			@(negedge clk);
			#1;
		end
		// memory and I/O commands finish while busy, pass-through never goes busy
		check_bit("busy", r.op != OP_PASS, busy);
		check_bit("wb_en", en, wb_en);
		if (en) begin
			check_rd("wb_rd_adr", r.rd_adr, wb_rd_adr);
			check_data("wb_data", r.exp, wb_data);
		end
		@(negedge clk);
	endtask

	initial begin : run_table
		int i;
		rst_n      = 1'b0;
		cmd_ld     = 1'b0;
		cmd_st     = 1'b0;
		ldst_code  = rv_dmem_pkg::LS_W;
		addr       = '0;
		st_data    = '0;
		rd_adr     = '0;
		wbk_rd_reg = 1'b0;
		rd_data    = '0;
		fetch_go   = 1'b0;
		fill_table();
		if (nrows != NROWS) begin
			$display("Stimulus table holds %0d rows instead of %0d", nrows, NROWS);
			abort_run();
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#1;
		check_bit("busy", 1'b0, busy);
		check_bit("wb_en", 1'b0, wb_en);
		check_bit("fetch_ack", 1'b0, fetch_ack);
		@(negedge clk);
		for (i = 0; i < NROWS; i++) begin
			apply_row(i);
			// fetch region is written, let the fetch port loose
			if (i == 3)
				fetch_go = 1'b1;
		end
		cmd_ld = 1'b0;
		cmd_st = 1'b0;
		wait (fetch_done);
		$display("Simulation completed successfully");
		$finish;
	end

	initial begin : fetch_traffic
		int          gap;
		int          k;
		logic [31:0] fa;
		fetch_cyc  = 1'b0;
		fetch_stb  = 1'b0;
		fetch_adr  = '0;
		fetch_done = 1'b0;
		wait (fetch_go);
		for (k = 0; k < NFETCH; k++) begin
			// at least one idle cycle so that cyc really drops between fetches
			gap = 1 + $unsigned($random(seed)) % 4;
			repeat (gap) @(negedge clk);
			fa        = ($unsigned($random(seed)) % 4) * 4;
			fetch_adr = fa;
			fetch_cyc = 1'b1;
			fetch_stb = 1'b1;
			@(negedge clk);
			while (!fetch_ack)
				@(negedge clk);
			check_data("fetch_dat", ram_word(fa), fetch_dat);
			// release once the ack cycle is over
			@(negedge clk);
			fetch_cyc = 1'b0;
			fetch_stb = 1'b0;
		end
		fetch_done = 1'b1;
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Run hung: table rows and fetches did not complete in time");
		abort_run();
	end

endmodule

// ==== rv_dmem.f ====
verilog/rv_dmem_pkg.sv
verilog/data_ram.sv
verilog/io_regs.sv
verilog/wb_arbiter.sv
verilog/mem_access_stage.sv
verilog/rv_dmem_top.sv
dv/tb_rv_dmem.sv
